// ==== verilog/rvIsaPkg.sv ====
// RV32I subset only: no compressed forms, jalr, system ops or sub-word loads and stores
package rvIsaPkg;

	// Major opcodes, instruction bits [6:0]
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} opcodeE;

	// ALU operation is {funct7[5], funct3}
	typedef enum logic [3:0] {
		ADD = 4'b0000,
		SUB = 4'b1000,
		SLL = 4'b0001,
		SLT = 4'b0010,
		XOR = 4'b0100,
		SRL = 4'b0101,
		SRA = 4'b1101,
		OR  = 4'b0110,
		AND = 4'b0111
	} aluOpE;

	// funct3 values that decode looks at directly
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_SRX = 3'b101; // srl, sra and their immediate forms

endpackage

// ==== verilog/pipePkg.sv ====
// Pipeline-wide constants; the decoder slices fixed 32-bit fields, so XLEN must stay 32
package pipePkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	localparam logic [31:0] NOP_INST = 32'h0000_0013; // addi x0, x0, 0

	// Control bits that travel with an instruction from decode onward
	typedef struct packed {
		logic            regWrite;
		logic            memRead;
		logic            memWrite;
		logic            memToReg;
		logic            aluSrc;
		logic            isJump;   // jal, write back the link address
		rvIsaPkg::aluOpE aluOp;
	} ctrlT;

endpackage

// ==== verilog/resultBusIf.sv ====
// Register-write result of one stage; rd and data mean nothing while regWrite is low
interface resultBusIf #(
	parameter int XLEN = pipePkg::XLEN
);
	logic                           regWrite;
	logic [pipePkg::REG_ADDR_W-1:0] rd;
	logic [XLEN-1:0]                data;
	logic                           isLoad;   // data is not the final value yet

	modport source (output regWrite, rd, data, isLoad);
	modport sink   (input  regWrite, rd, data, isLoad);
endinterface

// ==== verilog/fetchStage.sv ====
// Word-aligned fetch only; the instruction port returns the word in the same cycle
module fetchStage #(
	parameter int XLEN = pipePkg::XLEN
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            freeze,
	input  logic            hold,
	input  logic            redirect,
	input  logic [XLEN-1:0] target,
	input  logic [XLEN-1:0] imemRdata,
	output logic [XLEN-3:0] imemAddr,
	output logic [XLEN-1:0] idPc,
	output logic [XLEN-1:0] idPcPlus4,
	output logic [XLEN-1:0] idInst
);
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pcPlus4;
	logic            advance;

	assign pcPlus4  = pc + XLEN'(4);
	assign imemAddr = pc[XLEN-1:2];
	assign advance  = !(freeze || hold);

	// PC and fetched word
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc     <= '0;
			idInst <= pipePkg::NOP_INST;
		end else if (advance) begin
			pc     <= redirect ? target : pcPlus4;
			// Word after a taken branch or jal is squashed
			idInst <= redirect ? pipePkg::NOP_INST : {<<8{imemRdata}};
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			idPc      <= pc;
			idPcPlus4 <= pcPlus4;
		end
	end

endmodule

// ==== verilog/regFile.sv ====
// x0 is hardwired to zero; a read of the register being written returns the new value
module regFile #(
	parameter int XLEN = pipePkg::XLEN
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [pipePkg::REG_ADDR_W-1:0] rs1,
	input  logic [pipePkg::REG_ADDR_W-1:0] rs2,
	resultBusIf.sink                       wb,
	output logic [XLEN-1:0]                rs1Data,
	output logic [XLEN-1:0]                rs2Data
);
	localparam int RW   = pipePkg::REG_ADDR_W;
	localparam int NREG = 2 ** RW;

	logic [XLEN-1:0] regs [1:NREG-1];

	function automatic logic [XLEN-1:0] readPort(input logic [RW-1:0] addr);
		if (addr == '0) begin
			return '0;
		end
		if (wb.regWrite && wb.rd == addr) begin
			return wb.data; // write-through
		end
		return regs[addr];
	endfunction

	always_comb begin
		rs1Data = readPort(rs1);
		rs2Data = readPort(rs2);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.regWrite && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

endmodule

// ==== verilog/decodeStage.sv ====
// Branches resolve here; a source still in execute, or a load in memory, costs a bubble
module decodeStage #(
	parameter int XLEN = pipePkg::XLEN
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           freeze,
	input  logic [XLEN-1:0]                idPc,
	input  logic [XLEN-1:0]                idPcPlus4,
	input  logic [XLEN-1:0]                idInst,
	resultBusIf.sink                       memBus,
	resultBusIf.sink                       wbBus,
	output logic                           hold,
	output logic                           redirect,
	output logic [XLEN-1:0]                target,
	output pipePkg::ctrlT                  exCtrl,
	output logic [pipePkg::REG_ADDR_W-1:0] exRs1,
	output logic [pipePkg::REG_ADDR_W-1:0] exRs2,
	output logic [XLEN-1:0]                exRs1Data,
	output logic [XLEN-1:0]                exRs2Data,
	output logic [XLEN-1:0]                exImm,
	output logic [pipePkg::REG_ADDR_W-1:0] exRd,
	output logic [XLEN-1:0]                exPcPlus4,
	output logic                           exIsLoad
);
	localparam int RW = pipePkg::REG_ADDR_W;

	logic [RW-1:0]   rs1;
	logic [RW-1:0]   rs2;
	logic [RW-1:0]   rd;
	logic [2:0]      funct3;
	logic [XLEN-1:0] rs1Data;
	logic [XLEN-1:0] rs2Data;
	logic [XLEN-1:0] cmpA;
	logic [XLEN-1:0] cmpB;
	logic [XLEN-1:0] immI;
	logic [XLEN-1:0] immS;
	logic [XLEN-1:0] immB;
	logic [XLEN-1:0] immJ;
	logic [XLEN-1:0] imm;
	pipePkg::ctrlT   ctrl;
	logic            isBranch;
	logic            useRs1;
	logic            useRs2;
	logic            taken;
	logic            loadUse;
	logic            branchDep;

	assign rs1    = idInst[19:15];
	assign rs2    = idInst[24:20];
	assign rd     = idInst[11:7];
	assign funct3 = idInst[14:12];

	regFile #(.XLEN(XLEN)) regFile_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs1     (rs1),
		.rs2     (rs2),
		.wb      (wbBus),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data)
	);

	assign immI = {{(XLEN-11){idInst[31]}}, idInst[30:20]};
	assign immS = {{(XLEN-11){idInst[31]}}, idInst[30:25], idInst[11:7]};
	assign immB = {{(XLEN-12){idInst[31]}}, idInst[7], idInst[30:25], idInst[11:8], 1'b0};
	assign immJ = {{(XLEN-20){idInst[31]}}, idInst[19:12], idInst[20], idInst[30:21], 1'b0};

	// ==================================================================
	// Main and ALU control
	// ==================================================================
	always_comb begin
		ctrl       = '0;
		ctrl.aluOp = rvIsaPkg::ADD; // address and default add
		isBranch   = 1'b0;
		useRs1     = 1'b0;
		useRs2     = 1'b0;
		imm        = immI;
		case (rvIsaPkg::opcodeE'(idInst[6:0]))
			rvIsaPkg::OP: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = rvIsaPkg::aluOpE'({idInst[30], funct3});
				useRs1        = 1'b1;
				useRs2        = 1'b1;
			end
			rvIsaPkg::OP_IMM: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				// Only srai keeps funct7[5]
				ctrl.aluOp = rvIsaPkg::aluOpE'({funct3 == rvIsaPkg::F3_SRX && idInst[30], funct3});
				useRs1     = 1'b1;
				if (funct3[1:0] == 2'b01) begin
					imm = {{(XLEN-5){1'b0}}, idInst[24:20]}; // shamt
				end
			end
			rvIsaPkg::LOAD: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
				useRs1        = 1'b1;
			end
			rvIsaPkg::STORE: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				useRs1        = 1'b1;
				useRs2        = 1'b1;
				imm           = immS;
			end
			rvIsaPkg::BRANCH: begin
				isBranch = 1'b1;
				useRs1   = 1'b1;
				useRs2   = 1'b1;
			end
			rvIsaPkg::JAL: begin
				ctrl.regWrite = 1'b1;
				ctrl.isJump   = 1'b1;
			end
			default: ; // Unsupported opcode runs as a bubble
		endcase
	end

	// ==================================================================
	// Branch resolution and hazards
	// ==================================================================
	function automatic logic [XLEN-1:0] memFwd(
		input logic [RW-1:0]   src,
		input logic [XLEN-1:0] regVal
	);
		if (src != '0 && memBus.regWrite && memBus.rd == src) begin
			return memBus.data;
		end
		return regVal; // already holds the writeback value
	endfunction

	function automatic logic reads(input logic [RW-1:0] dst);
		return dst != '0 && ((useRs1 && dst == rs1) || (useRs2 && dst == rs2));
	endfunction

	always_comb begin
		cmpA = memFwd(rs1, rs1Data);
		cmpB = memFwd(rs2, rs2Data);
		// A load in memory has no data for the comparator yet
		loadUse = (exIsLoad && reads(exRd))
			|| (isBranch && memBus.isLoad && memBus.regWrite && reads(memBus.rd));
		branchDep = isBranch && exCtrl.regWrite && reads(exRd);
	end

	assign taken = isBranch
		&& ((funct3 == rvIsaPkg::F3_BEQ && cmpA == cmpB)
		|| (funct3 == rvIsaPkg::F3_BNE && cmpA != cmpB));
	assign target   = idPc + (ctrl.isJump ? immJ : immB);
	assign hold     = loadUse || branchDep;
	assign redirect = !hold && (ctrl.isJump || taken);

	// ID/EX register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exCtrl   <= '0;
			exIsLoad <= 1'b0;
		end else if (!freeze) begin
			exCtrl   <= hold ? pipePkg::ctrlT'('0) : ctrl; // bubble on hold
			exIsLoad <= !hold && ctrl.memRead;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			exRs1     <= rs1;
			exRs2     <= rs2;
			exRs1Data <= rs1Data;
			exRs2Data <= rs2Data;
			exImm     <= imm;
			exRd      <= rd;
			exPcPlus4 <= idPcPlus4;
		end
	end

endmodule

// ==== verilog/executeStage.sv ====
// The stall logic keeps a load out of memory while its consumer executes, so no load check here
module executeStage #(
	parameter int XLEN = pipePkg::XLEN
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           freeze,
	input  pipePkg::ctrlT                  exCtrl,
	input  logic [pipePkg::REG_ADDR_W-1:0] exRs1,
	input  logic [pipePkg::REG_ADDR_W-1:0] exRs2,
	input  logic [XLEN-1:0]                exRs1Data,
	input  logic [XLEN-1:0]                exRs2Data,
	input  logic [XLEN-1:0]                exImm,
	input  logic [pipePkg::REG_ADDR_W-1:0] exRd,
	input  logic [XLEN-1:0]                exPcPlus4,
	resultBusIf.sink                       wbBus,
	resultBusIf.source                     memBus,
	output pipePkg::ctrlT                  memCtrl,
	output logic [XLEN-1:0]                memStoreData,
	output logic [XLEN-1:0]                memPcPlus4
);
	localparam int RW  = pipePkg::REG_ADDR_W;
	localparam int SHW = $clog2(XLEN);

	logic [XLEN-1:0] opA;
	logic [XLEN-1:0] opB;
	logic [XLEN-1:0] storeVal;
	logic [XLEN-1:0] aluOut;
	logic [XLEN-1:0] resultQ;
	logic [RW-1:0]   rdQ;

	// ==================================================================
	// Operand forwarding
	// ==================================================================
	function automatic logic [XLEN-1:0] fwd(
		input logic [RW-1:0]   src,
		input logic [XLEN-1:0] regVal
	);
		if (src != '0 && memBus.regWrite && memBus.rd == src) begin
			return memBus.data; // Youngest producer wins
		end
		if (src != '0 && wbBus.regWrite && wbBus.rd == src) begin
			return wbBus.data;
		end
		return regVal;
	endfunction

	always_comb begin
		opA      = fwd(exRs1, exRs1Data);
		storeVal = fwd(exRs2, exRs2Data);
		opB      = exCtrl.aluSrc ? exImm : storeVal;
	end

	// ==================================================================
	// ALU
	// ==================================================================
	always_comb begin
		case (exCtrl.aluOp)
			rvIsaPkg::ADD: aluOut = opA + opB;
			rvIsaPkg::SUB: aluOut = opA - opB;
			rvIsaPkg::SLL: aluOut = opA << opB[SHW-1:0];
			rvIsaPkg::SLT: aluOut = XLEN'($signed(opA) < $signed(opB));
			rvIsaPkg::XOR: aluOut = opA ^ opB;
			rvIsaPkg::SRL: aluOut = opA >> opB[SHW-1:0];
			rvIsaPkg::SRA: aluOut = $signed(opA) >>> opB[SHW-1:0];
			rvIsaPkg::OR:  aluOut = opA | opB;
			rvIsaPkg::AND: aluOut = opA & opB;
			default:       aluOut = '0; // sltu and friends are not decoded
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			memCtrl <= '0;
		end else if (!freeze) begin
			memCtrl <= exCtrl;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			resultQ      <= aluOut;
			memStoreData <= storeVal;
			rdQ          <= exRd;
			memPcPlus4   <= exPcPlus4;
		end
	end

	assign memBus.regWrite = memCtrl.regWrite;
	assign memBus.rd       = rdQ;
	assign memBus.data     = memCtrl.isJump ? memPcPlus4 : resultQ; // Link is what jal writes
	assign memBus.isLoad   = memCtrl.memRead;

endmodule

// ==== verilog/memWbStage.sv ====
// Word accesses only; data words are byte-reversed in both directions at the port
module memWbStage #(
	parameter int XLEN = pipePkg::XLEN
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            freeze,
	resultBusIf.sink        memBus,
	input  pipePkg::ctrlT   memCtrl,
	input  logic [XLEN-1:0] memStoreData,
	input  logic [XLEN-1:0] memPcPlus4,
	input  logic [XLEN-1:0] dmemRdata,
	output logic            dmemRead,
	output logic            dmemWrite,
	output logic [XLEN-3:0] dmemAddr,
	output logic [XLEN-1:0] dmemWdata,
	resultBusIf.source      wbBus
);
	logic [XLEN-1:0]                loadData;
	logic [XLEN-1:0]                resultQ;
	logic [XLEN-1:0]                loadQ;
	logic [XLEN-1:0]                linkQ;
	logic [pipePkg::REG_ADDR_W-1:0] rdQ;
	logic                           regWriteQ;
	logic                           memToRegQ;
	logic                           isJumpQ;

	// Data port straight from EX/MEM
	assign dmemRead  = memCtrl.memRead;
	assign dmemWrite = memCtrl.memWrite;
	assign dmemAddr  = memBus.data[XLEN-1:2];
	assign dmemWdata = {<<8{memStoreData}};
	assign loadData  = {<<8{dmemRdata}};

	// MEM/WB register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			regWriteQ <= 1'b0;
			memToRegQ <= 1'b0;
			isJumpQ   <= 1'b0;
		end else if (!freeze) begin
			regWriteQ <= memBus.regWrite;
			memToRegQ <= memCtrl.memToReg;
			isJumpQ   <= memCtrl.isJump;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			resultQ <= memBus.data;
			loadQ   <= loadData;
			linkQ   <= memPcPlus4;
			rdQ     <= memBus.rd;
		end
	end

	assign wbBus.regWrite = regWriteQ;
	assign wbBus.rd       = rdQ;
	assign wbBus.data     = isJumpQ ? linkQ : (memToRegQ ? loadQ : resultQ);
	assign wbBus.isLoad   = memToRegQ;

endmodule

// ==== verilog/rvCore.sv ====
// Either port's stall freezes the whole pipeline; requests then stay on the ports unchanged
module rvCore #(
	parameter int XLEN = pipePkg::XLEN
) (
	input  logic            clk,
	input  logic            rst_n,
	output logic [XLEN-3:0] imemAddr,
	input  logic [XLEN-1:0] imemRdata,
	input  logic            imemStall,
	output logic            dmemRead,
	output logic            dmemWrite,
	output logic [XLEN-3:0] dmemAddr,
	output logic [XLEN-1:0] dmemWdata,
	input  logic [XLEN-1:0] dmemRdata,
	input  logic            dmemStall
);
	localparam int RW = pipePkg::REG_ADDR_W;

	logic            freeze;
	logic            hold;
	logic            redirect;
	logic [XLEN-1:0] target;
	logic [XLEN-1:0] idPc;
	logic [XLEN-1:0] idPcPlus4;
	logic [XLEN-1:0] idInst;
	pipePkg::ctrlT   exCtrl;
	logic [RW-1:0]   exRs1;
	logic [RW-1:0]   exRs2;
	logic [XLEN-1:0] exRs1Data;
	logic [XLEN-1:0] exRs2Data;
	logic [XLEN-1:0] exImm;
	logic [RW-1:0]   exRd;
	logic [XLEN-1:0] exPcPlus4;
	pipePkg::ctrlT   memCtrl;
	logic [XLEN-1:0] memStoreData;
	logic [XLEN-1:0] memPcPlus4;

	resultBusIf #(.XLEN(XLEN)) memBus ();
	resultBusIf #(.XLEN(XLEN)) wbBus ();

	assign freeze = imemStall || dmemStall;

	fetchStage #(.XLEN(XLEN)) fetchStage_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.freeze    (freeze),
		.hold      (hold),
		.redirect  (redirect),
		.target    (target),
		.imemRdata (imemRdata),
		.imemAddr  (imemAddr),
		.idPc      (idPc),
		.idPcPlus4 (idPcPlus4),
		.idInst    (idInst)
	);

	decodeStage #(.XLEN(XLEN)) decodeStage_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.freeze    (freeze),
		.idPc      (idPc),
		.idPcPlus4 (idPcPlus4),
		.idInst    (idInst),
		.memBus    (memBus),
		.wbBus     (wbBus),
		.hold      (hold),
		.redirect  (redirect),
		.target    (target),
		.exCtrl    (exCtrl),
		.exRs1     (exRs1),
		.exRs2     (exRs2),
		.exRs1Data (exRs1Data),
		.exRs2Data (exRs2Data),
		.exImm     (exImm),
		.exRd      (exRd),
		.exPcPlus4 (exPcPlus4),
		.exIsLoad  ()            // Only used inside decode
	);

	executeStage #(.XLEN(XLEN)) executeStage_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.freeze       (freeze),
		.exCtrl       (exCtrl),
		.exRs1        (exRs1),
		.exRs2        (exRs2),
		.exRs1Data    (exRs1Data),
		.exRs2Data    (exRs2Data),
		.exImm        (exImm),
		.exRd         (exRd),
		.exPcPlus4    (exPcPlus4),
		.wbBus        (wbBus),
		.memBus       (memBus),
		.memCtrl      (memCtrl),
		.memStoreData (memStoreData),
		.memPcPlus4   (memPcPlus4)
	);

	memWbStage #(.XLEN(XLEN)) memWbStage_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.freeze       (freeze),
		.memBus       (memBus),
		.memCtrl      (memCtrl),
		.memStoreData (memStoreData),
		.memPcPlus4   (memPcPlus4),
		.dmemRdata    (dmemRdata),
		.dmemRead     (dmemRead),
		.dmemWrite    (dmemWrite),
		.dmemAddr     (dmemAddr),
		.dmemWdata    (dmemWdata),
		.wbBus        (wbBus)
	);

endmodule

// ==== tests/coreAssert_assert.sv ====
// Checks the data-port handshake only; the instruction port is not covered
module coreAssert (
	input logic        clk,
	input logic        rst_n,
	input logic        dmemRead,
	input logic        dmemWrite,
	input logic [29:0] dmemAddr,
	input logic [31:0] dmemWdata,
	input logic        dmemStall
);

	// One request type at a time
	strobeExclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(dmemRead && dmemWrite))
		else $error("dmemRead and dmemWrite high together");

	// A frozen pipeline keeps the request on the port
	stallStable: assert property (@(posedge clk) disable iff (!rst_n)
		dmemStall |=> ($stable(dmemAddr) && $stable(dmemWdata)))
		else $error("data port request changed during a stall");

	resetQuiet: assert property (@(posedge clk)
		$rose(rst_n) |-> (!dmemRead && !dmemWrite))
		else $error("data strobe high right after reset");

endmodule

// ==== tests/tbCore.sv ====
// Word-only memory models with byte-reversed storage; programs end in a jal self-loop
module tbCore;

	localparam int XLEN        = 32;
	localparam int MEM_WORDS   = 64;
	localparam int TOTAL_WORDS = 80;  // Sum of all program lengths rounded up
	localparam int SETTLE      = 20;

	logic            clk;
	logic            rst_n;
	logic [XLEN-3:0] imemAddr;
	logic [XLEN-1:0] imemRdata;
	logic            imemStall;
	logic            dmemRead;
	logic            dmemWrite;
	logic [XLEN-3:0] dmemAddr;
	logic [XLEN-1:0] dmemWdata;
	logic [XLEN-1:0] dmemRdata;
	logic            dmemStall;

	logic [XLEN-1:0] imem [MEM_WORDS];
	logic [XLEN-1:0] dmem [MEM_WORDS];
	logic [XLEN-3:0] storeAddr [$];
	logic [XLEN-1:0] storeData [$];
	logic [XLEN-3:0] expAddr [$];
	logic [XLEN-1:0] expData [$];
	int              progLen;
	int              errors;
	logic            stallOn;

	rvCore #(.XLEN(XLEN)) rvCore_inst (.*);

	bind rvCore coreAssert coreAssert_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.dmemRead  (dmemRead),
		.dmemWrite (dmemWrite),
		.dmemAddr  (dmemAddr),
		.dmemWdata (dmemWdata),
		.dmemStall (dmemStall)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	assign imemRdata = imem[imemAddr[5:0]];
	assign dmemRdata = dmemRead ? dmem[dmemAddr[5:0]] : '0; // Data only while strobed

	// Store capture and data memory update on completed requests
	// A request completes only where the whole pipeline moves on
	always @(posedge clk) begin
		if (dmemWrite && !dmemStall && !imemStall) begin
			storeAddr.push_back(dmemAddr);
			storeData.push_back({<<8{dmemWdata}});
			dmem[dmemAddr[5:0]] <= dmemWdata;
		end
	end

	always @(posedge clk) begin
		if (stallOn) begin
			imemStall <= ($urandom % 4) == 0;
			dmemStall <= ($urandom % 4) == 0;
		end else begin
			imemStall <= 1'b0;
			dmemStall <= 1'b0;
		end
	end

	// ==================================================================
	// Instruction encoders straight from the RV32I formats
	// ==================================================================
	function automatic logic [31:0] rType(input logic [6:0] f7, input int rs2, input int rs1,
		input logic [2:0] f3, input int rd);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input int rs1,
		input logic [2:0] f3, input int rd, input logic [6:0] op);
		return {imm, 5'(rs1), f3, 5'(rd), op};
	endfunction

	function automatic logic [31:0] sw(input int rs2, input logic [11:0] imm, input int rs1);
		return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] bType(input logic [2:0] f3, input int rs1, input int rs2,
		input logic [12:0] imm);
		return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jal(input int rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
	endfunction

	function automatic logic [31:0] addi(input int rd, input int rs1, input logic [11:0] imm);
		return iType(imm, rs1, 3'b000, rd, 7'b0010011);
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[progLen] = {<<8{word}};
		progLen++;
	endtask

	task automatic expectStore(input int byteAddr, input logic [31:0] value);
		expAddr.push_back(30'(byteAddr >> 2));
		expData.push_back(value);
	endtask

	task automatic clearMemories();
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = {<<8{addi(0, 0, 12'(i))}};   // Harmless filler words
			dmem[i] = 32'hDEAD_0000 ^ (i * 32'h0101_0101);
		end
		progLen = 0;
		expAddr.delete();
		expData.delete();
	endtask

	// Reset, run until the expected stores are in, then compare
	task automatic runProgram(input string name);
		int cycles;
		rst_n <= 1'b0;
		repeat (10) @(posedge clk);
		storeAddr.delete();
		storeData.delete();
		rst_n <= 1'b1;
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			if (dmemRead || dmemWrite) begin
				$display("%s: data strobe high before any memory instruction", name);
				errors++;
			end
		end
		cycles = 0;
		while (storeAddr.size() < expAddr.size() && cycles < progLen * 40) begin
			@(posedge clk);
			cycles++;
		end
		repeat (SETTLE) @(posedge clk);   // Catch stray stores from skipped paths
		if (storeAddr.size() != expAddr.size()) begin
			$display("%s: saw %0d stores but expected %0d", name, storeAddr.size(),
				expAddr.size());
			errors++;
		end else begin
			for (int i = 0; i < expAddr.size(); i++) begin
				if (storeAddr[i] !== expAddr[i]) begin
					$display("MISMATCH %s dmemAddr[%0d]: expected 0x%08h, got 0x%08h",
						name, i, expAddr[i], storeAddr[i]);
					errors++;
				end
				if (storeData[i] !== expData[i]) begin
					$display("MISMATCH %s dmemWdata[%0d]: expected 0x%08h, got 0x%08h",
						name, i, expData[i], storeData[i]);
					errors++;
				end
			end
		end
	endtask

	// ==================================================================
	// Directed tests
	// ==================================================================
	task automatic aluChainTest(input string name);
		clearMemories();
		emit(addi(1, 0, -12'sd20));
		emit(addi(2, 0, 12'd3));
		emit(rType(7'h00, 2, 1, 3'b000, 3));   // add
		emit(rType(7'h20, 2, 3, 3'b000, 4));   // sub
		emit(rType(7'h00, 2, 2, 3'b001, 5));   // sll
		emit(rType(7'h00, 2, 1, 3'b010, 6));   // slt on negative vs positive
		emit(rType(7'h00, 1, 5, 3'b100, 7));   // xor
		emit(rType(7'h00, 2, 1, 3'b101, 8));   // srl
		emit(rType(7'h20, 2, 1, 3'b101, 9));   // sra on a negative value
		emit(rType(7'h00, 2, 7, 3'b110, 10));  // or
		emit(rType(7'h00, 1, 10, 3'b111, 11)); // and
		emit(iType(12'h004, 11, 3'b001, 12, 7'b0010011)); // slli
		emit(iType(12'h402, 1, 3'b101, 13, 7'b0010011));  // srai
		emit(iType(12'h055, 13, 3'b100, 14, 7'b0010011)); // xori
		for (int r = 3; r <= 14; r++) begin
			emit(sw(r, 12'(64 + 4 * (r - 3)), 0));
		end
		emit(jal(0, 21'd0));
		expectStore(64, 32'hFFFF_FFEF);
		expectStore(68, 32'hFFFF_FFEC);
		expectStore(72, 32'h0000_0018);
		expectStore(76, 32'h0000_0001);
		expectStore(80, 32'hFFFF_FFF4);
		expectStore(84, 32'h1FFF_FFFD);
		expectStore(88, 32'hFFFF_FFFD);
		expectStore(92, 32'hFFFF_FFF7);
		expectStore(96, 32'hFFFF_FFE4);
		expectStore(100, 32'hFFFF_FE40);
		expectStore(104, 32'hFFFF_FFFB);
		expectStore(108, 32'hFFFF_FFAE);
		runProgram(name);
	endtask

	task automatic loadUseTest();
		clearMemories();
		dmem[32] = {<<8{32'h1234_5678}};
		emit(addi(1, 0, 12'h080));
		emit(iType(12'd0, 1, 3'b010, 2, 7'b0000011)); // lw x2, 0(x1)
		emit(rType(7'h00, 1, 2, 3'b000, 3));          // add uses the load at once
		emit(sw(3, 12'd4, 1));
		emit(jal(0, 21'd0));
		expectStore(32'h84, 32'h1234_56F8);
		runProgram("loadUse");
	endtask

	task automatic branchTest();
		clearMemories();
		emit(addi(1, 0, 12'd5));
		emit(addi(2, 0, 12'd5));
		emit(addi(3, 0, 12'd7));
		emit(bType(3'b000, 1, 2, 13'd8)); // beq taken
		emit(sw(3, 12'h040, 0));
		emit(sw(1, 12'h044, 0));
		emit(bType(3'b001, 1, 2, 13'd8)); // bne not taken
		emit(sw(2, 12'h048, 0));
		emit(bType(3'b001, 1, 3, 13'd8)); // bne taken
		emit(sw(3, 12'h04C, 0));
		emit(bType(3'b000, 1, 3, 13'd8)); // beq not taken
		emit(sw(3, 12'h050, 0));
		emit(jal(0, 21'd0));
		expectStore(32'h44, 32'd5);
		expectStore(32'h48, 32'd5);
		expectStore(32'h50, 32'd7);
		runProgram("branch");
	endtask

	task automatic jalTest();
		clearMemories();
		emit(addi(1, 0, 12'd9));
		emit(jal(5, 21'd8));      // Link is 8 for the jal at pc 4
		emit(addi(1, 0, 12'd1));  // Skipped
		emit(sw(5, 12'h060, 0));
		emit(sw(1, 12'h064, 0));
		emit(jal(0, 21'd0));
		expectStore(32'h60, 32'd8);
		expectStore(32'h64, 32'd9);
		runProgram("jal");
	endtask

	// Watchdog
	initial begin
		#(TOTAL_WORDS * 40 * 20 + 6 * 40 * 20);
		$display("Watchdog expired before the tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(65218));
		errors    = 0;
		stallOn   = 1'b0;
		rst_n     = 1'b0;
		imemStall = 1'b0;
		dmemStall = 1'b0;
		clearMemories();
		aluChainTest("aluChain");
		loadUseTest();
		branchTest();
		jalTest();
		stallOn <= 1'b1;
		aluChainTest("aluChainStalled");
		stallOn <= 1'b0;
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
verilog/rvIsaPkg.sv
verilog/pipePkg.sv
verilog/resultBusIf.sv
verilog/fetchStage.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/rvCore.sv
tests/coreAssert_assert.sv
tests/tbCore.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = tbCore
FILELIST = tb.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
